/* Makefile */
SIM  := obj_dir/Vtb_atop_filter
SRCS := $(filter-out +%,$(shell cat vlog.f)) logic/axi_defines.svh

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source, the header or the file list changes.
$(SIM): vlog.f $(SRCS)
	verilator --binary --timing --assert -f vlog.f --top-module tb_atop_filter -o Vtb_atop_filter

# The exit status of the simulator is the test result.
run: $(SIM)
	./$(SIM)

clean:
	rm -rf obj_dir

/* logic/atop_filter_top.sv */
// Atomic operation filter in front of the AXI4 word memory, one AXI4 slave port.
`default_nettype none

module atop_filter_top
  import axi_pkg::*;
(
  input  wire logic     clk_i,
  input  wire logic     rst_ni,
  input  wire axi_req_t slv_req_i,
  output axi_resp_t     slv_resp_o
);

  // Filter to memory.
  axi_req_t  mem_req;
  axi_resp_t mem_resp;

  axi_atop_filter i_filter (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .slv_req_i  (slv_req_i),
    .slv_resp_o (slv_resp_o),
    .mst_req_o  (mem_req),
    .mst_resp_i (mem_resp)
  );

  axi_mem_slave i_mem (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .req_i  (mem_req),
    .resp_o (mem_resp)
  );

endmodule

`default_nettype wire

/* logic/axi_atop_filter.sv */
// AXI4 filter that absorbs atomic write bursts and answers them with SLVERR responses.
`default_nettype none

`include "axi_defines.svh"

module axi_atop_filter
  import axi_pkg::*;
#(
  parameter int unsigned MaxWriteTxns = `AXI_MAX_WRITE_TXNS
) (
  input  wire logic      clk_i,
  input  wire logic      rst_ni,
  input  wire axi_req_t  slv_req_i,
  output axi_resp_t      slv_resp_o,
  output axi_req_t       mst_req_o,
  input  wire axi_resp_t mst_resp_i
);

  localparam int unsigned CntWidth = $clog2(MaxWriteTxns + 1);

  // Extra bit so that -1 is representable.
  typedef logic signed [CntWidth:0] cnt_t;

  typedef enum logic [2:0] {
    W_FEEDTHROUGH, W_BLOCK_AW, W_ABSORB, W_HOLD_B, W_INJECT_B, W_WAIT_R
  } w_state_e;

  typedef enum logic [1:0] {R_FEEDTHROUGH, R_INJECT, R_HOLD} r_state_e;

  // Beats to inject for one atomic load.
  typedef struct packed {
    len_t len;
  } r_cmd_t;

  w_state_e w_state_d, w_state_q, w_done_state;
  r_state_e r_state_d, r_state_q;
  cnt_t     w_cnt_d, w_cnt_q;
  id_t      id_d, id_q;
  len_t     r_beats_d, r_beats_q;
  r_cmd_t   cmd_push, cmd_pop;
  logic     cmd_push_valid, cmd_push_ready, cmd_pop_valid, cmd_pop_ready;
  logic     aw_pending_w, w_pending_aw, aw_is_atop, fwd_b_stalled, fwd_r_stalled;
  logic     mst_aw_valid, mst_w_valid, mst_b_ready, mst_r_ready;
  logic     slv_aw_ready, slv_w_ready, slv_b_valid, slv_r_valid;
  b_chan_t  slv_b;
  r_chan_t  slv_r;

  // Downstream holds an AW still waiting for W data.
  assign aw_pending_w  = w_cnt_q > 0;
  // Downstream holds a full W burst ahead of its AW.
  assign w_pending_aw  = w_cnt_q == -1;
  assign aw_is_atop    = slv_req_i.aw_valid && (slv_req_i.aw.atop[5:4] != ATOP_NONE);
  assign fwd_b_stalled = mst_resp_i.b_valid && !slv_req_i.b_ready;
  assign fwd_r_stalled = mst_resp_i.r_valid && !slv_req_i.r_ready;
  // After the last absorbed W beat, wait out a stalled B first.
  assign w_done_state  = fwd_b_stalled ? W_HOLD_B : W_INJECT_B;
  assign cmd_push.len  = slv_req_i.aw.len;

  // Write side FSM.
  always_comb begin
    mst_aw_valid   = 1'b0;
    slv_aw_ready   = 1'b0;
    mst_w_valid    = 1'b0;
    slv_w_ready    = 1'b0;
    mst_b_ready    = slv_req_i.b_ready;
    slv_b_valid    = mst_resp_i.b_valid;
    slv_b          = mst_resp_i.b;
    id_d           = id_q;
    cmd_push_valid = 1'b0;
    w_state_d      = w_state_q;
    unique case (w_state_q)
      W_FEEDTHROUGH: begin
        // Forward AW while below the burst limit.
        if (w_pending_aw || (int'(w_cnt_q) < int'(MaxWriteTxns))) begin
          mst_aw_valid = slv_req_i.aw_valid;
          slv_aw_ready = mst_resp_i.aw_ready;
        end
        // W may run ahead of a plain AW, but only one burst deep.
        if (aw_pending_w || (slv_req_i.aw_valid && !aw_is_atop && !w_pending_aw)) begin
          mst_w_valid = slv_req_i.w_valid;
          slv_w_ready = mst_resp_i.w_ready;
        end
        if (aw_is_atop) begin
          // Take the atomic AW here, it never goes downstream.
          mst_aw_valid = 1'b0;
          slv_aw_ready = 1'b1;
          id_d         = slv_req_i.aw.id;
          // Loads, swaps and compares also need R beats.
          cmd_push_valid = slv_req_i.aw.atop[5:4] != ATOP_ATOMICSTORE;
          if (aw_pending_w) begin
            w_state_d = W_BLOCK_AW;
          end else begin
            mst_w_valid = 1'b0;
            slv_w_ready = 1'b1;
            if (slv_req_i.w_valid && slv_req_i.w.last) begin
              w_state_d = w_done_state;
            end else begin
              w_state_d = W_ABSORB;
            end
          end
        end
      end
      W_BLOCK_AW: begin
        // Let older W bursts drain first.
        if (aw_pending_w) begin
          mst_w_valid = slv_req_i.w_valid;
          slv_w_ready = mst_resp_i.w_ready;
        end else begin
          slv_w_ready = 1'b1;
          if (slv_req_i.w_valid && slv_req_i.w.last) begin
            w_state_d = w_done_state;
          end else begin
            w_state_d = W_ABSORB;
          end
        end
      end
      W_ABSORB: begin
        slv_w_ready = 1'b1;
        if (slv_req_i.w_valid && slv_req_i.w.last) begin
          w_state_d = w_done_state;
        end
      end
      W_HOLD_B: begin
        if (mst_resp_i.b_valid && slv_req_i.b_ready) begin
          w_state_d = W_INJECT_B;
        end
      end
      W_INJECT_B: begin
        // Own error response, downstream B waits.
        mst_b_ready = 1'b0;
        slv_b_valid = 1'b1;
        slv_b.id    = id_q;
        slv_b.resp  = RESP_SLVERR;
        if (slv_req_i.b_ready) begin
          if (cmd_pop_valid && !cmd_pop_ready) begin
            w_state_d = W_WAIT_R;
          end else begin
            w_state_d = W_FEEDTHROUGH;
          end
        end
      end
      W_WAIT_R: begin
        if (!cmd_pop_valid || cmd_pop_ready) begin
          w_state_d = W_FEEDTHROUGH;
        end
      end
      default: w_state_d = W_FEEDTHROUGH;
    endcase
  end

  // Read side FSM.
  always_comb begin
    slv_r         = mst_resp_i.r;
    slv_r_valid   = mst_resp_i.r_valid;
    mst_r_ready   = slv_req_i.r_ready;
    cmd_pop_ready = 1'b0;
    r_beats_d     = r_beats_q;
    r_state_d     = r_state_q;
    unique case (r_state_q)
      R_FEEDTHROUGH: begin
        if (fwd_r_stalled) begin
          r_state_d = R_HOLD;
        end else if (cmd_pop_valid) begin
          r_beats_d = cmd_pop.len;
          r_state_d = R_INJECT;
        end else if (cmd_push_valid) begin
          // Start right after the push, no need to wait for the register.
          r_beats_d = cmd_push.len;
          r_state_d = R_INJECT;
        end
      end
      R_INJECT: begin
        mst_r_ready = 1'b0;
        slv_r_valid = 1'b1;
        slv_r       = '0;
        slv_r.id    = id_q;
        slv_r.resp  = RESP_SLVERR;
        slv_r.last  = r_beats_q == '0;
        if (slv_req_i.r_ready) begin
          if (slv_r.last) begin
            cmd_pop_ready = 1'b1;
            r_state_d     = R_FEEDTHROUGH;
          end else begin
            r_beats_d = r_beats_q - len_t'(1);
          end
        end
      end
      R_HOLD: begin
        if (mst_resp_i.r_valid && slv_req_i.r_ready) begin
          r_beats_d = cmd_pop.len;
          r_state_d = cmd_pop_valid ? R_INJECT : R_FEEDTHROUGH;
        end
      end
      default: r_state_d = R_FEEDTHROUGH;
    endcase
  end

  // Downstream request, atop always cleared.
  always_comb begin
    mst_req_o          = '0;
    mst_req_o.aw       = slv_req_i.aw;
    mst_req_o.aw.atop  = '0;
    mst_req_o.aw_valid = mst_aw_valid;
    mst_req_o.w        = slv_req_i.w;
    mst_req_o.w_valid  = mst_w_valid;
    mst_req_o.b_ready  = mst_b_ready;
    mst_req_o.ar       = slv_req_i.ar;
    mst_req_o.ar_valid = slv_req_i.ar_valid;
    mst_req_o.r_ready  = mst_r_ready;
  end

  // Upstream response.
  always_comb begin
    slv_resp_o          = '0;
    slv_resp_o.aw_ready = slv_aw_ready;
    slv_resp_o.w_ready  = slv_w_ready;
    slv_resp_o.b        = slv_b;
    slv_resp_o.b_valid  = slv_b_valid;
    slv_resp_o.ar_ready = mst_resp_i.ar_ready;
    slv_resp_o.r        = slv_r;
    slv_resp_o.r_valid  = slv_r_valid;
  end

  // Count AW handshakes up and last W handshakes down.
  always_comb begin
    w_cnt_d = w_cnt_q;
    if (mst_aw_valid && mst_resp_i.aw_ready) begin
      w_cnt_d = w_cnt_d + cnt_t'(1);
    end
    if (mst_w_valid && mst_resp_i.w_ready && slv_req_i.w.last) begin
      w_cnt_d = w_cnt_d - cnt_t'(1);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      w_state_q <= W_FEEDTHROUGH;
      r_state_q <= R_FEEDTHROUGH;
      w_cnt_q   <= '0;
      id_q      <= '0;
      r_beats_q <= '0;
    end else begin
      w_state_q <= w_state_d;
      r_state_q <= r_state_d;
      w_cnt_q   <= w_cnt_d;
      id_q      <= id_d;
      r_beats_q <= r_beats_d;
    end
  end

  stream_register #(
    .T (r_cmd_t)
  ) i_r_cmd (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .valid_i (cmd_push_valid),
    .ready_o (cmd_push_ready),
    .data_i  (cmd_push),
    .valid_o (cmd_pop_valid),
    .ready_i (cmd_pop_ready),
    .data_o  (cmd_pop)
  );

  // An atomic AW upstream never reaches the memory side.
  a_no_atop_fwd: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mst_req_o.aw_valid |-> (mst_req_o.aw.atop == '0) && !aw_is_atop);

  // The write FSM only takes a new atomic once the previous R command drained.
  a_cmd_room: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cmd_push_valid |-> cmd_push_ready);

endmodule

`default_nettype wire

/* logic/axi_defines.svh */
// Bus widths, outstanding write burst limit and memory depth of the AXI subsystem.
`ifndef AXI_DEFINES_SVH
`define AXI_DEFINES_SVH

// Transaction ID bits.
`define AXI_ID_WIDTH 4

// Byte address bits.
`define AXI_ADDR_WIDTH 16

// Data bus bits, one memory word per beat.
`define AXI_DATA_WIDTH 32

// Default limit on write bursts outstanding downstream of the filter.
`define AXI_MAX_WRITE_TXNS 2

// Memory depth in words.
`define AXI_MEM_WORDS 256

`endif

/* logic/axi_mem_slave.sv */
// AXI4 word memory serving one INCR write burst and one INCR read burst at a time.
`default_nettype none

`include "axi_defines.svh"

module axi_mem_slave
  import axi_pkg::*;
(
  input  wire logic     clk_i,
  input  wire logic     rst_ni,
  input  wire axi_req_t req_i,
  output axi_resp_t     resp_o
);

  localparam int unsigned OffsetBits = $clog2(`AXI_DATA_WIDTH / 8);
  localparam int unsigned IdxBits    = $clog2(`AXI_MEM_WORDS);

  typedef logic [IdxBits-1:0] idx_t;

  typedef enum logic [1:0] {WR_IDLE, WR_ACCEPT, WR_DATA, WR_RESP} wr_state_e;
  typedef enum logic [1:0] {RD_IDLE, RD_ACCEPT, RD_DATA} rd_state_e;

  data_t     mem_q [`AXI_MEM_WORDS];
  wr_state_e wr_state_q;
  rd_state_e rd_state_q;
  id_t       wr_id_q, rd_id_q;
  idx_t      wr_idx_q, rd_idx_q, ar_idx;
  len_t      rd_left_q;
  data_t     rd_data_q;
  logic      aw_hs, w_hs, ar_hs, r_hs, r_last;

  // Ready and valid come straight from the engine states.
  always_comb begin
    resp_o          = '0;
    resp_o.aw_ready = wr_state_q == WR_ACCEPT;
    resp_o.w_ready  = wr_state_q == WR_DATA;
    resp_o.b_valid  = wr_state_q == WR_RESP;
    resp_o.b.id     = wr_id_q;
    resp_o.b.resp   = RESP_OKAY;
    resp_o.ar_ready = rd_state_q == RD_ACCEPT;
    resp_o.r_valid  = rd_state_q == RD_DATA;
    resp_o.r.id     = rd_id_q;
    resp_o.r.data   = rd_data_q;
    resp_o.r.resp   = RESP_OKAY;
    resp_o.r.last   = r_last;
  end

  assign aw_hs  = req_i.aw_valid && resp_o.aw_ready;
  assign w_hs   = req_i.w_valid && resp_o.w_ready;
  assign ar_hs  = req_i.ar_valid && resp_o.ar_ready;
  assign r_hs   = resp_o.r_valid && req_i.r_ready;
  assign r_last = rd_left_q == '0;
  // Word index from the byte address.
  assign ar_idx = req_i.ar.addr[OffsetBits +: IdxBits];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_state_q <= WR_IDLE;
      rd_state_q <= RD_IDLE;
    end else begin
      unique case (wr_state_q)
        WR_IDLE:   if (req_i.aw_valid) wr_state_q <= WR_ACCEPT;
        WR_ACCEPT: wr_state_q <= WR_DATA;
        WR_DATA:   if (w_hs && req_i.w.last) wr_state_q <= WR_RESP;
        WR_RESP:   if (req_i.b_ready) wr_state_q <= WR_IDLE;
        default:   wr_state_q <= WR_IDLE;
      endcase
      unique case (rd_state_q)
        RD_IDLE:   if (req_i.ar_valid) rd_state_q <= RD_ACCEPT;
        RD_ACCEPT: rd_state_q <= RD_DATA;
        RD_DATA:   if (r_hs && r_last) rd_state_q <= RD_IDLE;
        default:   rd_state_q <= RD_IDLE;
      endcase
    end
  end

  // Storage and burst address counters.
  always_ff @(posedge clk_i) begin
    if (aw_hs) begin
      wr_id_q  <= req_i.aw.id;
      wr_idx_q <= req_i.aw.addr[OffsetBits +: IdxBits];
    end
    if (w_hs) begin
      mem_q[wr_idx_q] <= req_i.w.data;
      wr_idx_q        <= wr_idx_q + idx_t'(1);
    end
    // Read data is registered one word ahead, so it holds under back-pressure.
    if (ar_hs) begin
      rd_id_q   <= req_i.ar.id;
      rd_left_q <= req_i.ar.len;
      rd_data_q <= mem_q[ar_idx];
      rd_idx_q  <= ar_idx + idx_t'(1);
    end else if (r_hs) begin
      rd_left_q <= rd_left_q - len_t'(1);
      rd_data_q <= mem_q[rd_idx_q];
      rd_idx_q  <= rd_idx_q + idx_t'(1);
    end
  end

  // The filter upstream keeps atomics away from this memory.
  a_no_atop: assert property (@(posedge clk_i) disable iff (!rst_ni)
    aw_hs |-> req_i.aw.atop == '0);

endmodule

`default_nettype wire

/* logic/axi_pkg.sv */
// AXI4 field types, channel and bus structs, response, burst and atomic operation codes.
`default_nettype none

`include "axi_defines.svh"

package axi_pkg;

  // Field vectors.
  typedef logic [`AXI_ID_WIDTH-1:0]     id_t;
  typedef logic [`AXI_ADDR_WIDTH-1:0]   addr_t;
  typedef logic [`AXI_DATA_WIDTH-1:0]   data_t;
  typedef logic [`AXI_DATA_WIDTH/8-1:0] strb_t;
  typedef logic [7:0]                   len_t;
  typedef logic [2:0]                   size_t;
  typedef logic [5:0]                   atop_t;

  // Response codes.
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } resp_e;

  // Burst codes, the memory treats all of them as INCR.
  typedef enum logic [1:0] {
    BURST_FIXED = 2'b00,
    BURST_INCR  = 2'b01,
    BURST_WRAP  = 2'b10
  } burst_e;

  // Atomic operation class in atop[5:4].
  localparam logic [1:0] ATOP_NONE        = 2'b00;
  localparam logic [1:0] ATOP_ATOMICSTORE = 2'b01;

  typedef struct packed {
    id_t    id;
    addr_t  addr;
    len_t   len;
    size_t  size;
    burst_e burst;
    atop_t  atop;
  } aw_chan_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
    logic  last;
  } w_chan_t;

  typedef struct packed {
    id_t   id;
    resp_e resp;
  } b_chan_t;

  typedef struct packed {
    id_t    id;
    addr_t  addr;
    len_t   len;
    size_t  size;
    burst_e burst;
  } ar_chan_t;

  typedef struct packed {
    id_t   id;
    data_t data;
    resp_e resp;
    logic  last;
  } r_chan_t;

  // Master to slave direction.
  typedef struct packed {
    aw_chan_t aw;
    logic     aw_valid;
    w_chan_t  w;
    logic     w_valid;
    logic     b_ready;
    ar_chan_t ar;
    logic     ar_valid;
    logic     r_ready;
  } axi_req_t;

  // Slave to master direction.
  typedef struct packed {
    logic    aw_ready;
    logic    w_ready;
    b_chan_t b;
    logic    b_valid;
    logic    ar_ready;
    r_chan_t r;
    logic    r_valid;
  } axi_resp_t;

endpackage

`default_nettype wire

/* logic/stream_register.sv */
// One-entry valid/ready register with a type parameter for its payload.
`default_nettype none

module stream_register #(
  parameter type T = logic
) (
  input  wire logic clk_i,
  input  wire logic rst_ni,
  input  wire logic valid_i,
  output logic      ready_o,
  input  wire T     data_i,
  output logic      valid_o,
  input  wire logic ready_i,
  output T          data_o
);

  logic full_q;
  T     data_q;

  // Room when empty or when the held item leaves this cycle.
  assign ready_o = !full_q || ready_i;
  assign valid_o = full_q;
  assign data_o  = data_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      full_q <= 1'b0;
    end else if (ready_o) begin
      full_q <= valid_i;
    end
  end

  // Payload is loaded on every accepted push.
  always_ff @(posedge clk_i) begin
    if (valid_i && ready_o) begin
      data_q <= data_i;
    end
  end

  // A waiting item keeps its value until it is taken.
  a_hold_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_o && !ready_i |=> valid_o && $stable(data_o));

endmodule

`default_nettype wire

/* sim/tb_atop_filter.sv */
// Testbench for the atomic operation filter with LFSR stimulus, bus tasks, reference model and checks.
`default_nettype none

`include "axi_defines.svh"

module tb_atop_filter
  import axi_pkg::*;
();

  localparam int KindWrite     = 0;
  localparam int KindRead      = 1;
  localparam int KindStore     = 2;
  localparam int KindLoad      = 3;
  localparam int BytesPerWord  = `AXI_DATA_WIDTH / 8;
  // Init fills words 0 to 39, final read-back covers the same words.
  localparam int InitBursts    = 10;
  localparam int NumDirected   = 8;
  localparam int NumRandom     = 64;
  localparam int NumTxns       = 2 * InitBursts + NumDirected + NumRandom;
  localparam int TimeoutCycles = 40 * NumTxns;

  logic        clk_i;
  logic        rst_ni;
  axi_req_t    slv_req;
  axi_resp_t   slv_resp;
  logic [31:0] lfsr_q;
  data_t       shadow [int];
  data_t       wdata [$];
  data_t       exp_rdata [$];
  id_t         atomic_id;
  int          b_seen = 0;
  int          r_seen = 0;
  int          errors = 0;
  int          cycle_cnt = 0;

  atop_filter_top i_dut (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .slv_req_i  (slv_req),
    .slv_resp_o (slv_resp)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // Run length bound derived from the transaction count.
  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= TimeoutCycles) begin
      $display("Timeout after %0d cycles, a transaction never completed", cycle_cnt);
      $display("Simulation failed");
      $fatal(1);
    end
  end

  // Counts every B and R handshake, so stray responses show up.
  always @(negedge clk_i) begin
    if (rst_ni) begin
      if (slv_resp.b_valid && slv_req.b_ready) b_seen++;
      if (slv_resp.r_valid && slv_req.r_ready) r_seen++;
    end
  end

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit returned.
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int k = 0; k < n; k++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      val    = {val[30:0], fb};
    end
    return val;
  endfunction

  // Shadow memory model. Atomics never touch memory and get SLVERR.
  function automatic void model_txn(input int kind, input int word, input int len,
                                    output logic [1:0] exp_b, output int exp_beats,
                                    output logic [1:0] exp_rresp);
    exp_b     = RESP_OKAY;
    exp_beats = 0;
    exp_rresp = RESP_OKAY;
    exp_rdata.delete();
    case (kind)
      KindWrite: begin
        for (int i = 0; i <= len; i++) begin
          shadow[(word + i) % `AXI_MEM_WORDS] = wdata[i];
        end
      end
      KindStore: exp_b = RESP_SLVERR;
      KindLoad: begin
        exp_b     = RESP_SLVERR;
        exp_beats = len + 1;
        exp_rresp = RESP_SLVERR;
        for (int i = 0; i <= len; i++) begin
          exp_rdata.push_back('0);
        end
      end
      default: begin
        exp_beats = len + 1;
        for (int i = 0; i <= len; i++) begin
          exp_rdata.push_back(shadow[(word + i) % `AXI_MEM_WORDS]);
        end
      end
    endcase
  endfunction

  task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("FAIL at %0t: %s, got %0h, expected %0h", $time, what, got, exp);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  task automatic drive_aw(input aw_chan_t aw);
    @(posedge clk_i);
    slv_req.aw       <= aw;
    slv_req.aw_valid <= 1'b1;
    @(negedge clk_i);
    while (!slv_resp.aw_ready) @(negedge clk_i);
    @(posedge clk_i);
    slv_req.aw_valid <= 1'b0;
  endtask

  task automatic drive_ar(input ar_chan_t ar);
    @(posedge clk_i);
    slv_req.ar       <= ar;
    slv_req.ar_valid <= 1'b1;
    @(negedge clk_i);
    while (!slv_resp.ar_ready) @(negedge clk_i);
    @(posedge clk_i);
    slv_req.ar_valid <= 1'b0;
  endtask

  // One W beat per cycle at most, payload from wdata.
  task automatic drive_w(input int len);
    for (int i = 0; i <= len; i++) begin
      @(posedge clk_i);
      slv_req.w.data  <= wdata[i];
      slv_req.w.strb  <= '1;
      slv_req.w.last  <= (i == len);
      slv_req.w_valid <= 1'b1;
      @(negedge clk_i);
      while (!slv_resp.w_ready) @(negedge clk_i);
    end
    @(posedge clk_i);
    slv_req.w_valid <= 1'b0;
  endtask

  // Random b_ready, checks the held payload while stalled.
  task automatic collect_b(input id_t exp_id, input logic [1:0] exp_resp);
    b_chan_t     held_b;
    logic        held;
    logic        done;
    logic [31:0] rnd;
    held = 1'b0;
    done = 1'b0;
    while (!done) begin
      @(posedge clk_i);
      rnd = rand_bits(1);
      slv_req.b_ready <= rnd[0];
      @(negedge clk_i);
      if (held) begin
        check_eq(64'(slv_resp.b_valid), 64'd1, "B valid held under stall");
        check_eq(64'(slv_resp.b), 64'(held_b), "B payload held under stall");
      end
      if (slv_resp.b_valid && slv_req.b_ready) begin
        check_eq(64'(slv_resp.b.id), 64'(exp_id), "B id");
        check_eq(64'(slv_resp.b.resp), 64'(exp_resp), "B resp");
        done = 1'b1;
      end else begin
        held   = slv_resp.b_valid;
        held_b = slv_resp.b;
      end
    end
    @(posedge clk_i);
    slv_req.b_ready <= 1'b1;
  endtask

  // Random r_ready, compares each beat with exp_rdata.
  task automatic collect_r(input id_t exp_id, input int beats, input logic [1:0] exp_resp);
    r_chan_t     held_r;
    logic        held;
    logic [31:0] rnd;
    int          beat;
    held = 1'b0;
    beat = 0;
    while (beat < beats) begin
      @(posedge clk_i);
      rnd = rand_bits(1);
      slv_req.r_ready <= rnd[0];
      @(negedge clk_i);
      if (held) begin
        check_eq(64'(slv_resp.r_valid), 64'd1, "R valid held under stall");
        check_eq(64'(slv_resp.r), 64'(held_r), "R payload held under stall");
      end
      if (slv_resp.r_valid && slv_req.r_ready) begin
        check_eq(64'(slv_resp.r.id), 64'(exp_id), "R id");
        check_eq(64'(slv_resp.r.data), 64'(exp_rdata[beat]), "R data");
        check_eq(64'(slv_resp.r.resp), 64'(exp_resp), "R resp");
        check_eq(64'(slv_resp.r.last), 64'(beat == beats - 1), "R last");
        beat++;
        held = 1'b0;
      end else begin
        held   = slv_resp.r_valid;
        held_r = slv_resp.r;
      end
    end
    @(posedge clk_i);
    slv_req.r_ready <= 1'b1;
  endtask

  // Plain or atomic write burst, then response counts.
  task automatic run_write(input int kind, input id_t id, input int word, input int len);
    aw_chan_t    aw;
    logic [1:0]  exp_b;
    logic [1:0]  exp_rresp;
    logic [31:0] rnd;
    int          exp_beats;
    int          b0;
    int          r0;
    wdata.delete();
    for (int i = 0; i <= len; i++) begin
      wdata.push_back(data_t'(rand_bits(32)));
    end
    aw       = '0;
    aw.id    = id;
    aw.addr  = addr_t'(word * BytesPerWord);
    aw.len   = len_t'(len);
    aw.size  = 3'd2;
    aw.burst = BURST_INCR;
    rnd      = rand_bits(5);
    if (kind == KindStore) begin
      aw.atop = {ATOP_ATOMICSTORE, rnd[3:0]};
    end else if (kind == KindLoad) begin
      // Class 10 is a load, 11 a swap or compare.
      aw.atop = {1'b1, rnd[4:0]};
    end
    model_txn(kind, word, len, exp_b, exp_beats, exp_rresp);
    b0 = b_seen;
    r0 = r_seen;
    fork
      drive_aw(aw);
      drive_w(len);
      collect_b(id, exp_b);
      begin
        if (exp_beats > 0) collect_r(id, exp_beats, exp_rresp);
      end
    join
    repeat (3) @(posedge clk_i);
    check_eq(64'(b_seen - b0), 64'd1, "B count of write burst");
    check_eq(64'(r_seen - r0), 64'(exp_beats), "R beat count of write burst");
  endtask

  task automatic run_read(input id_t id, input int word, input int len);
    ar_chan_t   ar;
    logic [1:0] exp_b;
    logic [1:0] exp_rresp;
    int         exp_beats;
    int         b0;
    int         r0;
    ar       = '0;
    ar.id    = id;
    ar.addr  = addr_t'(word * BytesPerWord);
    ar.len   = len_t'(len);
    ar.size  = 3'd2;
    ar.burst = BURST_INCR;
    model_txn(KindRead, word, len, exp_b, exp_beats, exp_rresp);
    b0 = b_seen;
    r0 = r_seen;
    fork
      drive_ar(ar);
      collect_r(id, exp_beats, exp_rresp);
    join
    repeat (3) @(posedge clk_i);
    check_eq(64'(b_seen - b0), 64'd0, "B count of read burst");
    check_eq(64'(r_seen - r0), 64'(exp_beats), "R beat count of read burst");
  endtask

  initial begin
    int kind;
    int len;
    int word;
    slv_req         = '0;
    slv_req.b_ready = 1'b1;
    slv_req.r_ready = 1'b1;
    rst_ni          = 1'b0;
    lfsr_q          = 32'h9091;
    atomic_id       = '0;
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;
    repeat (2) @(posedge clk_i);

    // Known contents in words 0 to 39.
    for (int i = 0; i < InitBursts; i++) begin
      run_write(KindWrite, id_t'(rand_bits(4)), i * 4, 3);
    end
    run_read(id_t'(rand_bits(4)), 0, 3);
    run_read(id_t'(rand_bits(4)), 4, 3);
    run_read(id_t'(rand_bits(4)), 5, 0);

    // Atomic store, then old data must still be there.
    atomic_id = atomic_id + id_t'(1);
    run_write(KindStore, atomic_id, 8, 2);
    run_read(id_t'(rand_bits(4)), 8, 3);

    // Atomic loads with error beats.
    atomic_id = atomic_id + id_t'(1);
    run_write(KindLoad, atomic_id, 12, 3);
    atomic_id = atomic_id + id_t'(1);
    run_write(KindLoad, atomic_id, 20, 0);
    run_read(id_t'(rand_bits(4)), 12, 3);

    // Random mix over words 0 to 34.
    for (int n = 0; n < NumRandom; n++) begin
      kind = int'(rand_bits(2));
      len  = int'(rand_bits(2));
      word = int'(rand_bits(5));
      if (kind == KindRead) begin
        run_read(id_t'(rand_bits(4)), word, len);
      end else if (kind == KindWrite) begin
        run_write(kind, id_t'(rand_bits(4)), word, len);
      end else begin
        atomic_id = atomic_id + id_t'(1);
        run_write(kind, atomic_id, word, len);
      end
    end

    // Full read-back against the shadow copy.
    for (int i = 0; i < InitBursts; i++) begin
      run_read(id_t'(rand_bits(4)), i * 4, 3);
    end

    if (errors == 0) begin
      $display("Simulation completed successfully");
      $finish;
    end else begin
      $display("Simulation failed");
      $fatal(1);
    end
  end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+logic
logic/axi_pkg.sv
logic/stream_register.sv
logic/axi_atop_filter.sv
logic/axi_mem_slave.sv
logic/atop_filter_top.sv
sim/tb_atop_filter.sv
